// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dcache
FILELIST  = dcache.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Verification failed
RUN_ARGS  = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dcache.f ====
logic/dcache_pkg.sv
logic/dcache_dir_if.sv
logic/dcache_lookup.sv
logic/dcache_controller.sv
logic/dcache_result.sv
logic/dcache_top.sv
testbench/dcache_asserts.sv
testbench/dcache_checker.sv
testbench/tb_dcache.sv

// ==== logic/dcache_controller.sv ====
`timescale 1ns/1ps

module dcache_controller
  import dcache_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          access,
  input  addr_t         address,
  input  logic          op,
  input  logic          byte_op,
  input  word_t         data_in,
  input  logic          allow_op,
  input  logic          mem_data_ready,
  input  line_t         mem_data_out,
  dcache_dir_if.control dir,
  output logic          mem_req,
  output logic          mem_done,
  output logic          start_access,
  output logic          mem_op,
  output addr_t         mem_address,
  output line_t         mem_data_in,
  output logic          finish,
  output word_t         sel_word
);

  ctrl_state_t state;
  line_t       data_q [NUM_LINES];

  tag_t      cur_tag;
  word_off_t word_off;
  byte_off_t byte_off;

  logic  finish_d;
  logic  accept;
  logic  fill_done;
  logic  launch_wb;
  logic  launch_fill;
  line_t hit_data;
  line_t hit_merged;
  line_t fill_merged;

  // Apply a pending store to a line, byte lane or full word
  function automatic line_t merge_write(line_t line, word_off_t w, byte_off_t b,
                                        logic is_byte, word_t wdata);
    line_t result;
    result = line;
    if (is_byte)
    begin
      result[{w, b} * 8 +: 8] = wdata[7:0];
    end
    else
    begin
      result[w * WORD_WIDTH +: WORD_WIDTH] = wdata;
    end
    return result;
  endfunction

  function automatic addr_t line_addr(tag_t t);
    return {t, {(ADDR_WIDTH - TAG_WIDTH){1'b0}}};
  endfunction

  assign {cur_tag, word_off, byte_off} = address;

  // Ignore the held request until data_ready has gone by
  assign accept = (state == IDLE) && access && !finish && !finish_d;

  assign fill_done   = (state == FILL) && start_access && mem_data_ready;
  assign launch_wb   = (state == REQUEST) && allow_op && dir.victim_dirty;
  assign launch_fill = ((state == REQUEST) && allow_op && !dir.victim_dirty)
                    || ((state == FILL) && !start_access);

  assign hit_data    = data_q[dir.hit_line];
  assign hit_merged  = op ? hit_data
                          : merge_write(hit_data, word_off, byte_off, byte_op, data_in);
  assign fill_merged = op ? mem_data_out
                          : merge_write(mem_data_out, word_off, byte_off, byte_op, data_in);

  // Directory requests
  assign dir.lookup_tag = cur_tag;
  assign dir.touch      = accept && dir.hit;
  assign dir.touch_line = dir.hit_line;
  assign dir.install    = fill_done;
  assign dir.set_dirty  = !op && (dir.touch || fill_done);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state        <= IDLE;
      finish       <= 1'b0;
      finish_d     <= 1'b0;
      mem_req      <= 1'b0;
      mem_done     <= 1'b0;
      start_access <= 1'b0;
    end
    else
    begin
      finish   <= 1'b0;
      finish_d <= finish;
      mem_done <= 1'b0;
      case (state)
        IDLE:
        begin
          if (accept)
          begin
            if (dir.hit)
            begin
              finish <= 1'b1;
            end
            else
            begin
              mem_req <= 1'b1;
              state   <= REQUEST;
            end
          end
        end
        REQUEST:
        begin
          if (allow_op)
          begin
            start_access <= 1'b1;
            state        <= dir.victim_dirty ? WRITEBACK : FILL;
          end
        end
        WRITEBACK:
        begin
          // One idle cycle on start_access before the fill
          if (mem_data_ready)
          begin
            start_access <= 1'b0;
            state        <= FILL;
          end
        end
        FILL:
        begin
          if (!start_access)
          begin
            start_access <= 1'b1;
          end
          else if (mem_data_ready)
          begin
            start_access <= 1'b0;
            finish       <= 1'b1;
            state        <= RELEASE;
          end
        end
        RELEASE:
        begin
          mem_req  <= 1'b0;
          mem_done <= 1'b1;
          state    <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Memory transfer setup, data array and returned word
  always_ff @(posedge clk)
  begin
    if (launch_wb)
    begin
      mem_op      <= 1'b1;
      mem_address <= line_addr(dir.victim_tag);
      mem_data_in <= data_q[dir.victim_line];
    end
    else if (launch_fill)
    begin
      mem_op      <= 1'b0;
      mem_address <= line_addr(cur_tag);
    end

    if (dir.touch)
    begin
      if (!op)
      begin
        data_q[dir.hit_line] <= hit_merged;
      end
      sel_word <= hit_merged[word_off * WORD_WIDTH +: WORD_WIDTH];
    end

    if (fill_done)
    begin
      data_q[dir.victim_line] <= fill_merged;
      sel_word <= fill_merged[word_off * WORD_WIDTH +: WORD_WIDTH];
    end
  end

endmodule

// ==== logic/dcache_dir_if.sv ====
`timescale 1ns/1ps

interface dcache_dir_if
  import dcache_pkg::*;
();

  // Directory answers, combinational from lookup_tag
  logic      hit;
  line_idx_t hit_line;
  line_idx_t victim_line;
  logic      victim_dirty;
  tag_t      victim_tag;

  // Requests and update strobes from the controller
  tag_t      lookup_tag;
  logic      touch;
  line_idx_t touch_line;
  logic      install;
  logic      set_dirty;

  modport lookup (
    input  lookup_tag, touch, touch_line, install, set_dirty,
    output hit, hit_line, victim_line, victim_dirty, victim_tag
  );

  modport control (
    output lookup_tag, touch, touch_line, install, set_dirty,
    input  hit, hit_line, victim_line, victim_dirty, victim_tag
  );

endinterface

// ==== logic/dcache_lookup.sv ====
`timescale 1ns/1ps

module dcache_lookup
  import dcache_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  dcache_dir_if.lookup dir
);

  tag_t                 tags [NUM_LINES];
  logic [NUM_LINES-1:0] valid;
  logic [NUM_LINES-1:0] dirty;
  lru_rank_t            rank [NUM_LINES];

  logic [NUM_LINES-1:0] match;
  line_idx_t            target;
  lru_rank_t            target_rank;

  // Parallel tag compare over all lines
  always_comb
  begin
    dir.hit = 1'b0;
    dir.hit_line = '0;
    for (int i = 0; i < NUM_LINES; i++)
    begin
      match[i] = valid[i] && (tags[i] == dir.lookup_tag);
      if (match[i])
      begin
        dir.hit = 1'b1;
        dir.hit_line = line_idx_t'(i);
      end
    end
  end

  // Ranks form a permutation, so exactly one line sits at rank 0
  always_comb
  begin
    dir.victim_line = '0;
    for (int i = 0; i < NUM_LINES; i++)
    begin
      if (rank[i] == '0)
      begin
        dir.victim_line = line_idx_t'(i);
      end
    end
  end

  assign dir.victim_dirty = valid[dir.victim_line] && dirty[dir.victim_line];
  assign dir.victim_tag   = tags[dir.victim_line];

  // Install always lands on the victim
  assign target      = dir.install ? dir.victim_line : dir.touch_line;
  assign target_rank = rank[target];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid <= '0;
      dirty <= '0;
      for (int i = 0; i < NUM_LINES; i++)
      begin
        rank[i] <= lru_rank_t'(i);
      end
    end
    else
    begin
      if (dir.touch || dir.install)
      begin
        for (int i = 0; i < NUM_LINES; i++)
        begin
          if (line_idx_t'(i) == target)
          begin
            rank[i] <= lru_rank_t'(NUM_LINES - 1);
          end
          else if (rank[i] > target_rank)
          begin
            rank[i] <= rank[i] - 1'b1;
          end
        end
      end
      if (dir.install)
      begin
        valid[target] <= 1'b1;
        dirty[target] <= 1'b0;
      end
      // Later assignment wins over the clean from install
      if (dir.set_dirty)
      begin
        dirty[target] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (dir.install)
    begin
      tags[target] <= dir.lookup_tag;
    end
  end

endmodule

// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

  // Geometry of the cache and the CPU side
  localparam int ADDR_WIDTH      = 32;
  localparam int WORD_WIDTH      = 32;
  localparam int LINE_WIDTH      = 128;
  localparam int NUM_LINES       = 4;
  localparam int WORDS_PER_LINE  = 4;
  localparam int REG_INDEX_WIDTH = 5;

  // Address bits above the line offset
  localparam int TAG_WIDTH = 28;

  typedef logic [ADDR_WIDTH-1:0]             addr_t;
  typedef logic [WORD_WIDTH-1:0]             word_t;
  typedef logic [LINE_WIDTH-1:0]             line_t;
  typedef logic [TAG_WIDTH-1:0]              tag_t;
  typedef logic [$clog2(NUM_LINES)-1:0]      line_idx_t;
  typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_off_t;
  typedef logic [$clog2(WORD_WIDTH/8)-1:0]   byte_off_t;
  typedef logic [REG_INDEX_WIDTH-1:0]        reg_idx_t;

  // Recency rank, highest value is the most recently used line
  typedef logic [$clog2(NUM_LINES)-1:0] lru_rank_t;

  // Access sequencing in the controller
  typedef enum logic [2:0] {
    IDLE,
    REQUEST,
    WRITEBACK,
    FILL,
    RELEASE
  } ctrl_state_t;

endpackage

// ==== logic/dcache_result.sv ====
`timescale 1ns/1ps

module dcache_result
  import dcache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      finish,
  input  word_t     sel_word,
  input  byte_off_t byte_off,
  input  logic      byte_op,
  input  reg_idx_t  destination_register_in,
  output word_t     data_out,
  output logic      data_ready,
  output reg_idx_t  destination_register_out
);

  logic [7:0] sel_byte;
  word_t      result_word;

  // Byte lane of the addressed word
  assign sel_byte = sel_word[byte_off * 8 +: 8];

  // Byte loads are zero extended
  assign result_word = byte_op ? word_t'(sel_byte) : sel_word;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      data_ready <= 1'b0;
    end
    else
    begin
      data_ready <= finish;
    end
  end

  // Result and register index appear with data_ready
  always_ff @(posedge clk)
  begin
    if (finish)
    begin
      data_out                 <= result_word;
      destination_register_out <= destination_register_in;
    end
  end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
  import dcache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // CPU side
  input  logic     access,
  input  addr_t    address,
  input  logic     op,
  input  logic     byte_op,
  input  word_t    data_in,
  input  reg_idx_t destination_register_in,
  output word_t    data_out,
  output logic     data_ready,
  output reg_idx_t destination_register_out,
  // Arbiter and memory side
  input  logic     allow_op,
  input  logic     mem_data_ready,
  input  line_t    mem_data_out,
  output logic     mem_req,
  output logic     mem_done,
  output logic     start_access,
  output logic     mem_op,
  output addr_t    mem_address,
  output line_t    mem_data_in
);

  logic      finish;
  word_t     sel_word;
  byte_off_t byte_off;

  assign byte_off = address[$bits(byte_off_t)-1:0];

  dcache_dir_if dir ();

  dcache_lookup u_lookup (
    .clk   (clk),
    .reset (reset),
    .dir   (dir.lookup)
  );

  dcache_controller u_controller (
    .clk            (clk),
    .reset          (reset),
    .access         (access),
    .address        (address),
    .op             (op),
    .byte_op        (byte_op),
    .data_in        (data_in),
    .allow_op       (allow_op),
    .mem_data_ready (mem_data_ready),
    .mem_data_out   (mem_data_out),
    .dir            (dir.control),
    .mem_req        (mem_req),
    .mem_done       (mem_done),
    .start_access   (start_access),
    .mem_op         (mem_op),
    .mem_address    (mem_address),
    .mem_data_in    (mem_data_in),
    .finish         (finish),
    .sel_word       (sel_word)
  );

  dcache_result u_result (
    .clk                      (clk),
    .reset                    (reset),
    .finish                   (finish),
    .sel_word                 (sel_word),
    .byte_off                 (byte_off),
    .byte_op                  (byte_op),
    .destination_register_in  (destination_register_in),
    .data_out                 (data_out),
    .data_ready               (data_ready),
    .destination_register_out (destination_register_out)
  );

endmodule

// ==== testbench/dcache_asserts.sv ====
`timescale 1ns/1ps

module dcache_asserts
  import dcache_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  data_ready,
  input logic  mem_req,
  input logic  allow_op,
  input logic  start_access,
  input logic  mem_data_ready,
  input addr_t mem_address
);

  int fail_count = 0;

  ready_pulse: assert property (@(posedge clk) disable iff (reset) data_ready |=> !data_ready)
    else
    begin
      $error("data_ready held for more than one cycle");
      fail_count++;
    end

  // A transfer needs the bus request and the grant
  start_granted: assert property (@(posedge clk) disable iff (reset)
                                  start_access |-> (mem_req && allow_op))
    else
    begin
      $error("start_access without mem_req and allow_op");
      fail_count++;
    end

  addr_stable: assert property (@(posedge clk) disable iff (reset)
                                (start_access && !mem_data_ready) |=> $stable(mem_address))
    else
    begin
      $error("mem_address changed while a transfer was pending");
      fail_count++;
    end

endmodule

bind dcache_top dcache_asserts u_asserts (.*);

// ==== testbench/dcache_checker.sv ====
`timescale 1ns/1ps

module dcache_checker
  import dcache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     access,
  input  logic     op,
  input  logic     byte_op,
  input  addr_t    address,
  input  word_t    data_in,
  input  reg_idx_t destination_register_in,
  input  word_t    data_out,
  input  logic     data_ready,
  input  reg_idx_t destination_register_out,
  input  logic     mem_req,
  input  logic     mem_done,
  input  logic     start_access,
  input  logic     mem_op,
  input  addr_t    mem_address,
  input  line_t    mem_data_in,
  input  logic     mem_data_ready,
  input  word_t    exp_data,
  input  logic     exp_fill,
  input  int       assert_errors,
  input  logic     run_done,
  output int       error_total
);

  int       data_errors = 0;
  int       reg_errors = 0;
  int       mem_errors = 0;
  int       timing_errors = 0;
  logic     busy = 1'b0;
  logic     seen_access = 1'b0;
  int       cycles;
  int       fills;
  int       writebacks;
  addr_t    line_base;
  logic     cap_op;
  logic     cap_byte;
  addr_t    cap_addr;
  word_t    cap_wdata;
  reg_idx_t cap_dest;
  word_t    cap_data;
  logic     cap_fill;
  word_t    exp_word;
  addr_t    word_addr;
  word_t    shadow [addr_t];

  function automatic void log_error(string msg);
    $display("ERR %0d ns: %s", $time, msg);
  endfunction

  // Memory contents as the CPU stores have left them
  function automatic word_t expected_word(addr_t a);
    if (shadow.exists(a))
      return shadow[a];
    return a ^ 32'hA5A5_A5A5;
  endfunction

  assign error_total = data_errors + reg_errors + mem_errors + timing_errors + assert_errors;

  // Sampled at the falling edge, away from DUT and stimulus updates
  always @(negedge clk)
  begin
    if ((reset || !seen_access) && (data_ready || mem_req || start_access))
    begin
      timing_errors++;
      log_error("data_ready, mem_req or start_access high around reset");
    end
    if (!reset && access && !busy)
    begin
      busy        = 1'b1;
      seen_access = 1'b1;
      cycles      = 0;
      fills       = 0;
      writebacks  = 0;
      cap_op      = op;
      cap_byte    = byte_op;
      cap_addr    = address;
      cap_wdata   = data_in;
      cap_dest    = destination_register_in;
      cap_data    = exp_data;
      cap_fill    = exp_fill;
      line_base   = {address[ADDR_WIDTH-1:4], 4'h0};
    end
    else if (busy)
    begin
      cycles++;
      if (start_access && mem_data_ready && mem_op)
      begin
        writebacks++;
        // Victim goes out first, to its own aligned line
        if (fills != 0 || writebacks > 1 || mem_address == line_base || mem_address[3:0] != 4'h0)
        begin
          mem_errors++;
          log_error($sformatf("bad write-back to %h for line %h", mem_address, line_base));
        end
        for (int w = 0; w < WORDS_PER_LINE; w++)
        begin
          exp_word = expected_word(mem_address + addr_t'(4 * w));
          if (mem_data_in[w*WORD_WIDTH +: WORD_WIDTH] !== exp_word)
          begin
            mem_errors++;
            log_error($sformatf("write-back word %0d is %h, expected %h", w,
                                mem_data_in[w*WORD_WIDTH +: WORD_WIDTH], exp_word));
          end
        end
      end
      else if (start_access && mem_data_ready)
      begin
        fills++;
        if (mem_address != line_base)
        begin
          mem_errors++;
          log_error($sformatf("fill address %h, expected %h", mem_address, line_base));
        end
      end
      if (data_ready)
      begin
        busy = 1'b0;
        if (!cap_op)
        begin
          word_addr = {cap_addr[ADDR_WIDTH-1:2], 2'b00};
          exp_word  = expected_word(word_addr);
          if (cap_byte)
            exp_word[cap_addr[1:0]*8 +: 8] = cap_wdata[7:0];
          else
            exp_word = cap_wdata;
          shadow[word_addr] = exp_word;
        end
        if (cap_op && data_out !== cap_data)
        begin
          data_errors++;
          log_error($sformatf("read data %h, expected %h", data_out, cap_data));
        end
        if (destination_register_out !== cap_dest)
        begin
          reg_errors++;
          log_error($sformatf("register %0d, expected %0d", destination_register_out, cap_dest));
        end
        if (cap_fill && (fills != 1 || !mem_done))
        begin
          mem_errors++;
          log_error($sformatf("miss on %h saw %0d fills", line_base, fills));
        end
        if (!cap_fill && (fills != 0 || writebacks != 0))
        begin
          mem_errors++;
          log_error($sformatf("hit on %h issued a memory transfer", line_base));
        end
        // Access sampled at the next edge, data_ready one edge later
        if (!cap_fill && cycles != 2)
        begin
          timing_errors++;
          log_error($sformatf("hit took %0d cycles, expected 2", cycles));
        end
      end
    end
  end

  always @(posedge run_done)
    $display("Errors: data %0d, register %0d, memory %0d, timing %0d, assertion %0d",
             data_errors, reg_errors, mem_errors, timing_errors, assert_errors);

endmodule

// ==== testbench/dcache_testdata.txt ====
// op(1 read) byte_op address write_data dest_reg expected_read expect_fill
// All hex, one access per line, expect_fill 0 means a hit with no memory transfer
1 0 00001004 00000000 01 A5A5B5A1 1
1 0 0000100C 00000000 02 A5A5B5A9 0
1 0 00001004 00000000 03 A5A5B5A1 0
0 1 00001009 FFFFFF3C 04 00000000 0
1 1 00001009 00000000 05 0000003C 0
1 0 00001008 00000000 06 A5A53CAD 0
1 1 0000100B 00000000 07 000000A5 0
1 0 00002000 00000000 08 A5A585A5 1
1 0 00003000 00000000 09 A5A595A5 1
1 0 00004000 00000000 0A A5A5E5A5 1
1 0 00001000 00000000 0B A5A5B5A5 0
1 0 00005000 00000000 0C A5A5F5A5 1
1 0 00002004 00000000 0D A5A585A1 1
1 0 00001008 00000000 0E A5A53CAD 0
0 0 00004004 12345678 0F 00000000 0
1 0 00005008 00000000 10 A5A5F5AD 0
1 0 0000200C 00000000 11 A5A585A9 0
1 0 00006000 00000000 12 A5A5C5A5 1
1 0 00003008 00000000 13 A5A595AD 1
1 1 00001009 00000000 14 0000003C 1
1 0 00001008 00000000 15 A5A53CAD 0
1 0 00004004 00000000 16 12345678 1
0 1 00007002 123456EE 17 00000000 1
1 0 00007000 00000000 18 A5EED5A5 0
1 1 00007003 00000000 1F 000000A5 0

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache
  import dcache_pkg::*;
();

  localparam int FIELDS      = 7;
  localparam int MAX_VECTORS = 64;

  logic     clk;
  logic     reset;
  logic     access;
  addr_t    address;
  logic     op;
  logic     byte_op;
  word_t    data_in;
  reg_idx_t destination_register_in;
  word_t    data_out;
  logic     data_ready;
  reg_idx_t destination_register_out;
  logic     allow_op;
  logic     mem_data_ready;
  line_t    mem_data_out;
  logic     mem_req;
  logic     mem_done;
  logic     start_access;
  logic     mem_op;
  addr_t    mem_address;
  line_t    mem_data_in;

  word_t       exp_data;
  logic        exp_fill;
  logic        run_done;
  int          error_total;
  logic [31:0] vectors [FIELDS*MAX_VECTORS];
  int          num_vectors;
  int          cycle_count = 0;
  int          cycle_limit = 1000000;
  int          seed = 39;
  word_t       backing [addr_t];

  dcache_top u_dut (.*);

  dcache_checker u_checker (
    .assert_errors (u_dut.u_asserts.fail_count),
    .*
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout after %0d cycles while waiting for the cache", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  // Untouched memory words follow the address pattern
  function automatic word_t read_word(addr_t a);
    if (backing.exists(a))
      return backing[a];
    return a ^ 32'hA5A5_A5A5;
  endfunction

  function automatic line_t read_line(addr_t base);
    line_t line;
    for (int w = 0; w < WORDS_PER_LINE; w++)
      line[w*WORD_WIDTH +: WORD_WIDTH] = read_word(base + addr_t'(4 * w));
    return line;
  endfunction

  task automatic write_line(addr_t base, line_t line);
    for (int w = 0; w < WORDS_PER_LINE; w++)
      backing[base + addr_t'(4 * w)] = line[w*WORD_WIDTH +: WORD_WIDTH];
  endtask

  // Grant and ready delays of 1 to 4 cycles
  function automatic int random_delay();
    return 1 + ($unsigned($random(seed)) % 4);
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_vectors();
    for (int i = 0; i < FIELDS*MAX_VECTORS; i++)
      vectors[i] = 32'hFFFF_FFFF;
    $readmemh("testbench/dcache_testdata.txt", vectors);
    num_vectors = 0;
    while (num_vectors < MAX_VECTORS && vectors[num_vectors*FIELDS] != 32'hFFFF_FFFF)
      num_vectors++;
    cycle_limit = num_vectors * 40 + 100;
  endtask

  task automatic run_access(int idx);
    int base;
    base                    = idx * FIELDS;
    access                  = 1'b1;
    op                      = vectors[base][0];
    byte_op                 = vectors[base+1][0];
    address                 = vectors[base+2];
    data_in                 = vectors[base+3];
    destination_register_in = reg_idx_t'(vectors[base+4]);
    exp_data                = vectors[base+5];
    exp_fill                = vectors[base+6][0];
    do
      @(negedge clk);
    while (!data_ready);
    step_cycle();
    access = 1'b0;
  endtask

  // Arbiter and memory, one transfer at a time
  initial
  begin : mem_model
    int delay;
    allow_op       = 1'b0;
    mem_data_ready = 1'b0;
    mem_data_out   = '0;
    forever
    begin
      step_cycle();
      if (!mem_req)
        allow_op = 1'b0;
      else if (!allow_op)
      begin
        delay = random_delay();
        repeat (delay - 1) step_cycle();
        allow_op = 1'b1;
      end
      else if (start_access)
      begin
        delay = random_delay();
        repeat (delay - 1) step_cycle();
        if (mem_op)
          write_line(mem_address, mem_data_in);
        else
          mem_data_out = read_line(mem_address);
        mem_data_ready = 1'b1;
        step_cycle();
        mem_data_ready = 1'b0;
      end
    end
  end

  initial
  begin : stimulus
    reset                   = 1'b1;
    access                  = 1'b0;
    address                 = '0;
    op                      = 1'b0;
    byte_op                 = 1'b0;
    data_in                 = '0;
    destination_register_in = '0;
    exp_data                = '0;
    exp_fill                = 1'b0;
    run_done                = 1'b0;
    load_vectors();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    // A few idle cycles so the checker watches the outputs after reset
    step_cycle();
    step_cycle();
    for (int i = 0; i < num_vectors; i++)
      run_access(i);
    step_cycle();
    run_done = 1'b1;
    #1;
    if (num_vectors == 0)
      $display("No access was read from the test data file");
    if (num_vectors > 0 && error_total == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
